/* bench/conv_tb.sv */
`timescale 1ns/1ns

module conv_tb import conv_pkg::*;;

	localparam int IMAGE_WIDTH     = 4;
	localparam int CHANNEL_NUM_IN  = 4;
	localparam int CHANNEL_NUM_OUT = 4;
	localparam int GAP_CYCLES      = IMAGE_WIDTH + 1;
	localparam int OUT_SHIFT       = 4;

	localparam int IMAGE_SIZE  = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int FRAME_READS = CHANNEL_NUM_IN * IMAGE_SIZE;
	localparam int WGT_LOADS   = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;
	localparam int NUM_FRAMES  = 4;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * (FRAME_READS
		+ CHANNEL_NUM_OUT * (FRAME_READS + GAP_CYCLES) + WGT_LOADS) + 100;

	logic    clk;
	logic    reset;
	logic    pxl_valid;
	pixel_t  pxl_in;
	logic    wgt_valid;
	weight_t wgt_in;
	logic    result_valid;
	pixel_t  result;
	logic    done;

	int      seed = 32'h016c_eddf;
	int      error_count = 0;
	int      tests_run = 0;
	int      tests_failed = 0;
	int      results_seen = 0;
	int      done_count = 0;
	int      cycle_count = 0;
	pixel_t  exp_q [$];
	pixel_t  frame_pix [CHANNEL_NUM_IN][IMAGE_SIZE];
	weight_t wgt_mat [CHANNEL_NUM_OUT][CHANNEL_NUM_IN];

	conv_pointwise_top #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT),
		.GAP_CYCLES     (GAP_CYCLES),
		.OUT_SHIFT      (OUT_SHIFT)
	) i_dut (
		.clk         (clk),
		.reset       (reset),
		.pxl_valid   (pxl_valid),
		.pxl_in      (pxl_in),
		.wgt_valid   (wgt_valid),
		.wgt_in      (wgt_in),
		.result_valid(result_valid),
		.result      (result),
		.done        (done)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_result(input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			$display("** Error @ %0t: result %0d, expected %0d", $time, got, exp);
			error_count++;
		end
	endtask

	task automatic check_done(input int got, input int exp);
		if (got != exp) begin
			$display("** Error @ %0t: %0d done pulses, expected %0d", $time, got, exp);
			error_count++;
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) begin
			$display("** Error @ %0t: %0d results, expected %0d", $time, got, exp);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	// Sum over input channels, then ReLU, shift and clip to 127
	function automatic pixel_t model_output(input int oc, input int p);
		int sum;
		sum = 0;
		for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
			sum += int'(frame_pix[ic][p]) * int'(wgt_mat[oc][ic]);
		end
		if (sum < 0) begin
			sum = 0;
		end
		sum = sum >>> OUT_SHIFT;
		if (sum > 127) begin
			sum = 127;
		end
		return pixel_t'(sum);
	endfunction

	task automatic queue_expected();
		for (int oc = 0; oc < CHANNEL_NUM_OUT; oc++) begin
			for (int p = 0; p < IMAGE_SIZE; p++) begin
				exp_q.push_back(model_output(oc, p));
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic randomize_inputs();
		for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
			for (int p = 0; p < IMAGE_SIZE; p++) begin
				frame_pix[ic][p] = pixel_t'($random(seed));
			end
		end
		// Small weights keep most sums out of saturation
		for (int oc = 0; oc < CHANNEL_NUM_OUT; oc++) begin
			for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
				wgt_mat[oc][ic] = weight_t'($random(seed) % 8);
			end
		end
	endtask

	task automatic fill_constant(input pixel_t pix, input weight_t wgt);
		for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
			for (int p = 0; p < IMAGE_SIZE; p++) begin
				frame_pix[ic][p] = pix;
			end
			for (int oc = 0; oc < CHANNEL_NUM_OUT; oc++) begin
				wgt_mat[oc][ic] = wgt;
			end
		end
	endtask

	// Weights go first so the load is over before the last pixel
	task automatic run_frame();
		int base_results;
		int base_done;
		base_results = results_seen;
		base_done = done_count;
		queue_expected();
		for (int oc = 0; oc < CHANNEL_NUM_OUT; oc++) begin
			for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
				@(posedge clk);
				wgt_valid <= 1'b1;
				wgt_in <= wgt_mat[oc][ic];
			end
		end
		@(posedge clk);
		wgt_valid <= 1'b0;
		for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
			for (int p = 0; p < IMAGE_SIZE; p++) begin
				@(posedge clk);
				pxl_valid <= 1'b1;
				pxl_in <= frame_pix[ic][p];
			end
		end
		@(posedge clk);
		pxl_valid <= 1'b0;
		while (done_count == base_done) begin
			@(negedge clk);
		end
		// Idle a while to catch a second done pulse
		repeat (GAP_CYCLES + 2) @(negedge clk);
		check_done(done_count - base_done, 1);
		check_count(results_seen - base_results, CHANNEL_NUM_OUT * IMAGE_SIZE);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed", tests_run, name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor and timeout

	always @(posedge clk) begin
		if (!reset) begin
			if (result_valid) begin
				results_seen++;
				if (exp_q.size() == 0) begin
					$display("Result %0d at %0t arrived with none expected", result, $time);
					error_count++;
				end else begin
					check_result(result, exp_q.pop_front());
				end
			end
			if (done) begin
				done_count++;
				if (exp_q.size() != 0) begin
					$display("Done pulse at %0t came before the last result", $time);
					error_count++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles waiting for the DUT", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int errors_before;
		clk = 1'b0;
		reset = 1'b1;
		pxl_valid = 1'b0;
		pxl_in = '0;
		wgt_valid = 1'b0;
		wgt_in = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		errors_before = error_count;
		repeat (10) @(negedge clk);
		check_done(done_count, 0);
		check_count(results_seen, 0);
		report_test("idle after reset", errors_before);

		errors_before = error_count;
		randomize_inputs();
		run_frame();
		report_test("random frame", errors_before);

		// Largest positive pixels against both weight signs
		errors_before = error_count;
		fill_constant(pixel_t'(127), weight_t'(127));
		run_frame();
		fill_constant(pixel_t'(127), weight_t'(-128));
		run_frame();
		report_test("saturation and relu", errors_before);

		errors_before = error_count;
		randomize_inputs();
		run_frame();
		report_test("second random frame", errors_before);

		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* compile.f */
verilog/conv_pkg.sv
verilog/loop_data_buffer.sv
verilog/weight_store.sv
verilog/pointwise_accumulator.sv
verilog/conv_pointwise_top.sv
bench/conv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the conv_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module conv_tb \
	-f compile.f -Mdir "$OBJ" -o conv_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/conv_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides the outcome
if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0

/* verilog/conv_pkg.sv */
package conv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data widths

	// Pixels, weights and results share one width
	localparam int DATA_WIDTH = 8;

	// Partial sums must hold CHANNEL_NUM_IN products without overflow
	localparam int ACC_WIDTH = 20;

	////////////////////////////////////////////////////////////////////////////
	// Data types

	typedef logic signed [DATA_WIDTH-1:0] pixel_t;
	typedef logic signed [DATA_WIDTH-1:0] weight_t;
	typedef logic signed [ACC_WIDTH-1:0]  acc_t;

	// Loop buffer FSM
	typedef enum logic [1:0] {
		ST_FILL,
		ST_REPLAY,
		ST_GAP,
		ST_DONE
	} buf_state_t;

endpackage

/* verilog/conv_pointwise_top.sv */
`timescale 1ns/1ns

module conv_pointwise_top import conv_pkg::*; #(
	parameter int IMAGE_WIDTH     = 4,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4,
	parameter int GAP_CYCLES      = IMAGE_WIDTH + 1,
	parameter int OUT_SHIFT       = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    pxl_valid,
	input  pixel_t  pxl_in,
	input  logic    wgt_valid,
	input  weight_t wgt_in,
	output logic    result_valid,
	output pixel_t  result,
	output logic    done
);

	logic    rd_strobe;
	pixel_t  buf_pxl;
	logic    buf_pxl_valid;
	weight_t ws_wgt;
	logic    ws_wgt_valid;

	////////////////////////////////////////////////////////////////////////////
	// Frame replay and matching weights

	loop_data_buffer #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT),
		.GAP_CYCLES     (GAP_CYCLES)
	) i_buffer (
		.clk          (clk),
		.reset        (reset),
		.pxl_valid    (pxl_valid),
		.pxl_in       (pxl_in),
		.rd_strobe    (rd_strobe),
		.pxl_out      (buf_pxl),
		.pxl_out_valid(buf_pxl_valid),
		.done         (done)
	);

	weight_store #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) i_weights (
		.clk          (clk),
		.reset        (reset),
		.wgt_valid    (wgt_valid),
		.wgt_in       (wgt_in),
		.rd_strobe    (rd_strobe),
		.wgt_out      (ws_wgt),
		.wgt_out_valid(ws_wgt_valid)
	);

	// Both streams arrive 2 cycles after rd_strobe
	pointwise_accumulator #(
		.IMAGE_WIDTH   (IMAGE_WIDTH),
		.CHANNEL_NUM_IN(CHANNEL_NUM_IN),
		.OUT_SHIFT     (OUT_SHIFT)
	) i_accum (
		.clk         (clk),
		.reset       (reset),
		.pxl_valid   (buf_pxl_valid),
		.pxl         (buf_pxl),
		.wgt_valid   (ws_wgt_valid),
		.wgt         (ws_wgt),
		.result_valid(result_valid),
		.result      (result)
	);

endmodule

/* verilog/loop_data_buffer.sv */
`timescale 1ns/1ns

module loop_data_buffer import conv_pkg::*; #(
	parameter int IMAGE_WIDTH     = 4,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4,
	parameter int GAP_CYCLES      = IMAGE_WIDTH + 1
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   pxl_valid,
	input  pixel_t pxl_in,
	output logic   rd_strobe,
	output pixel_t pxl_out,
	output logic   pxl_out_valid,
	output logic   done
);

	localparam int FRAME_SIZE = CHANNEL_NUM_IN * IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int ADDR_W     = (FRAME_SIZE > 1) ? $clog2(FRAME_SIZE) : 1;
	localparam int PASS_W     = (CHANNEL_NUM_OUT > 1) ? $clog2(CHANNEL_NUM_OUT) : 1;
	localparam int GAP_W      = $clog2(GAP_CYCLES + 1);

	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME_SIZE - 1);
	localparam logic [PASS_W-1:0] LAST_PASS = PASS_W'(CHANNEL_NUM_OUT - 1);
	localparam logic [GAP_W-1:0]  LAST_GAP  = GAP_W'(GAP_CYCLES - 1);

	buf_state_t        state;
	logic [ADDR_W-1:0] addr;
	logic [PASS_W-1:0] pass_cnt;
	logic [GAP_W-1:0]  gap_cnt;
	logic              wr_en;

	// Frame memory, channel-major
	pixel_t mem [FRAME_SIZE];
	pixel_t rd_data;
	logic   rd_valid;

	// A strobe in ST_DONE is the first pixel of the next frame
	assign wr_en = pxl_valid && (state == ST_FILL || state == ST_DONE);

	////////////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_FILL;
			addr      <= '0;
			pass_cnt  <= '0;
			gap_cnt   <= '0;
			rd_strobe <= 1'b0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_FILL, ST_DONE: begin
					if (pxl_valid) begin
						if (addr == LAST_ADDR) begin
							addr      <= '0;
							state     <= ST_REPLAY;
							rd_strobe <= 1'b1;
						end else begin
							addr  <= addr + 1'b1;
							state <= ST_FILL;
						end
					end
				end
				ST_REPLAY: begin
					// Same counter now walks the read address
					if (addr == LAST_ADDR) begin
						addr      <= '0;
						gap_cnt   <= '0;
						state     <= ST_GAP;
						rd_strobe <= 1'b0;
					end else begin
						addr <= addr + 1'b1;
					end
				end
				ST_GAP: begin
					if (gap_cnt == LAST_GAP) begin
						gap_cnt <= '0;
						if (pass_cnt == LAST_PASS) begin
							pass_cnt <= '0;
							state    <= ST_DONE;
							done     <= 1'b1;
						end else begin
							pass_cnt  <= pass_cnt + 1'b1;
							state     <= ST_REPLAY;
							rd_strobe <= 1'b1;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= ST_FILL;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory and read pipeline

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[addr] <= pxl_in;
		end
		if (rd_strobe) begin
			rd_data <= mem[addr];
		end
		// Output stage
		if (rd_valid) begin
			pxl_out <= rd_data;
		end
	end

	// Strobe delayed to line up with the data
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid      <= 1'b0;
			pxl_out_valid <= 1'b0;
		end else begin
			rd_valid      <= rd_strobe;
			pxl_out_valid <= rd_valid;
		end
	end

	a_no_read_in_fill: assert property (@(posedge clk) disable iff (reset)
		state == ST_FILL |-> !rd_strobe);

endmodule

/* verilog/pointwise_accumulator.sv */
`timescale 1ns/1ns

module pointwise_accumulator import conv_pkg::*; #(
	parameter int IMAGE_WIDTH    = 4,
	parameter int CHANNEL_NUM_IN = 4,
	parameter int OUT_SHIFT      = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    pxl_valid,
	input  pixel_t  pxl,
	input  logic    wgt_valid,
	input  weight_t wgt,
	output logic    result_valid,
	output pixel_t  result
);

	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int POS_W      = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1;
	localparam int CH_W       = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;

	localparam logic [POS_W-1:0] LAST_POS = POS_W'(IMAGE_SIZE - 1);
	localparam logic [CH_W-1:0]  LAST_CH  = CH_W'(CHANNEL_NUM_IN - 1);

	// Largest positive result
	localparam acc_t RES_MAX = acc_t'((1 << (DATA_WIDTH - 1)) - 1);

	// One partial sum per pixel position
	acc_t psum [IMAGE_SIZE];

	logic [POS_W-1:0]               pos;
	logic [CH_W-1:0]                ch;
	logic                           pair_valid;
	logic                           last_ch;
	logic signed [2*DATA_WIDTH-1:0] prod_full;
	acc_t                           prod;
	acc_t                           sum;
	acc_t                           relu;
	acc_t                           shifted;

	////////////////////////////////////////////////////////////////////////////
	// Datapath

	assign pair_valid = pxl_valid && wgt_valid;
	assign last_ch    = (ch == LAST_CH);

	assign prod_full = pxl * wgt;
	assign prod      = acc_t'(prod_full);

	// Channel 0 starts a fresh sum
	assign sum     = (ch == '0) ? prod : psum[pos] + prod;
	assign relu    = (sum < 0) ? '0 : sum;
	assign shifted = relu >>> OUT_SHIFT;

	always_ff @(posedge clk) begin
		if (pair_valid) begin
			psum[pos] <= sum;
		end
		if (pair_valid && last_ch) begin
			result <= (shifted > RES_MAX) ? pixel_t'(RES_MAX) : pixel_t'(shifted);
		end
	end

	// Pixel position runs fastest, input channel above it
	always_ff @(posedge clk) begin
		if (reset) begin
			pos          <= '0;
			ch           <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= pair_valid && last_ch;
			if (pair_valid) begin
				if (pos == LAST_POS) begin
					pos <= '0;
					ch  <= last_ch ? '0 : ch + 1'b1;
				end else begin
					pos <= pos + 1'b1;
				end
			end
		end
	end

	a_streams_aligned: assert property (@(posedge clk) disable iff (reset)
		pxl_valid == wgt_valid);

endmodule

/* verilog/weight_store.sv */
`timescale 1ns/1ns

module weight_store import conv_pkg::*; #(
	parameter int IMAGE_WIDTH     = 4,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    wgt_valid,
	input  weight_t wgt_in,
	input  logic    rd_strobe,
	output weight_t wgt_out,
	output logic    wgt_out_valid
);

	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int NUM_WGT    = CHANNEL_NUM_OUT * CHANNEL_NUM_IN;
	localparam int IDX_W      = (NUM_WGT > 1) ? $clog2(NUM_WGT) : 1;
	localparam int PIX_W      = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1;
	localparam int IC_W       = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
	localparam int OC_W       = (CHANNEL_NUM_OUT > 1) ? $clog2(CHANNEL_NUM_OUT) : 1;

	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_WGT - 1);
	localparam logic [PIX_W-1:0] LAST_PIX = PIX_W'(IMAGE_SIZE - 1);
	localparam logic [IC_W-1:0]  LAST_IC  = IC_W'(CHANNEL_NUM_IN - 1);
	localparam logic [OC_W-1:0]  LAST_OC  = OC_W'(CHANNEL_NUM_OUT - 1);

	// Output channel major, then input channel
	weight_t wmem [NUM_WGT];

	logic [IDX_W-1:0] ld_idx;
	logic [IDX_W-1:0] rd_idx;
	logic [PIX_W-1:0] pix_cnt;
	logic [IC_W-1:0]  ic_cnt;
	logic [OC_W-1:0]  oc_cnt;
	weight_t          rd_data;
	logic             rd_valid;

	assign rd_idx = IDX_W'(oc_cnt * CHANNEL_NUM_IN + ic_cnt);

	// Load counter wraps so the next frame can reload
	always_ff @(posedge clk) begin
		if (reset) begin
			ld_idx <= '0;
		end else if (wgt_valid) begin
			ld_idx <= (ld_idx == LAST_IDX) ? '0 : ld_idx + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read position follows the buffer replay

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			ic_cnt  <= '0;
			oc_cnt  <= '0;
		end else if (rd_strobe) begin
			// Weight held for a whole input plane
			if (pix_cnt == LAST_PIX) begin
				pix_cnt <= '0;
				if (ic_cnt == LAST_IC) begin
					ic_cnt <= '0;
					oc_cnt <= (oc_cnt == LAST_OC) ? '0 : oc_cnt + 1'b1;
				end else begin
					ic_cnt <= ic_cnt + 1'b1;
				end
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wgt_valid) begin
			wmem[ld_idx] <= wgt_in;
		end
		if (rd_strobe) begin
			rd_data <= wmem[rd_idx];
		end
		if (rd_valid) begin
			wgt_out <= rd_data;
		end
	end

	// Same two-stage delay as the pixel path
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid      <= 1'b0;
			wgt_out_valid <= 1'b0;
		end else begin
			rd_valid      <= rd_strobe;
			wgt_out_valid <= rd_valid;
		end
	end

	a_no_load_during_read: assert property (@(posedge clk) disable iff (reset)
		!(wgt_valid && rd_strobe));

endmodule
